/* vlog.f */
+incdir+rtl
rtl/vertex_pkg.sv
rtl/setup_pkg.sv
rtl/payload_fifo.sv
rtl/bbox_unit.sv
rtl/edge_unit.sv
rtl/recip_unit.sv
rtl/setup_merge.sv
rtl/triangle_setup_top.sv
bench/tb_triangle_setup.sv

/* Makefile */
TOP       ?= tb_triangle_setup
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   ?= obj_dir

SRCS := $(shell grep -v '^+' vlog.f)
HDRS := $(wildcard rtl/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): vlog.f $(SRCS) $(HDRS)
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f vlog.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_triangle_setup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "setup_macros.svh"

module tb_triangle_setup
    import vertex_pkg::*, setup_pkg::*;
();

    localparam bit     CULL_BACK  = 1'b1;
    localparam int     NUM_TRIS   = 208;
    localparam longint TIMEOUT_NS = longint'(NUM_TRIS) * (`INV_BITS + 12) * 100 * 4;

    logic           clk;
    logic           rst;
    vertex_t        v0;
    vertex_t        v1;
    vertex_t        v2;
    logic           in_valid;
    logic           in_ready;
    sub_t           out_v0x;
    sub_t           out_v0y;
    sub_t           out_e0x;
    sub_t           out_e0y;
    sub_t           out_e1x;
    sub_t           out_e1y;
    inv_t           out_inv;
    logic           out_inv_ovf;
    scr_x_t         out_min_x;
    scr_x_t         out_max_x;
    scr_y_t         out_min_y;
    scr_y_t         out_max_y;
    color12_t [2:0] out_colors;
    q16_16_t  [2:0] out_depths;
    logic           out_valid;
    logic           out_ready;
    logic           busy;

    // expected records of kept triangles, oldest first
    bbox_rec_t exp_box_q[$];
    edge_rec_t exp_edge_q[$];
    inv_t      exp_inv_q[$];
    bit        exp_ovf_q[$];

    bbox_rec_t got_box;
    edge_rec_t got_edge;
    bit        ready_random;
    string     test_name;
    int        errors;
    int        checks;
    int        kept_cnt;
    int        out_cnt;
    int        tests_run;
    int        tests_failed;
    int        err_mark;
    int        kept_mark;
    int        out_mark;

    triangle_setup_top #(.cull_back(CULL_BACK)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic longint min3(input longint a, input longint b, input longint c);
        longint m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic longint max3(input longint a, input longint b, input longint c);
        longint m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic longint clamp_px(input longint v, input longint hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    function automatic bbox_rec_t model_bbox(input vertex_t a, input vertex_t b, input vertex_t c);
        bbox_rec_t r;
        longint    lo_x;
        longint    hi_x;
        longint    lo_y;
        longint    hi_y;
        lo_x = min3(a.x, b.x, c.x);
        hi_x = max3(a.x, b.x, c.x);
        lo_y = min3(a.y, b.y, c.y);
        hi_y = max3(a.y, b.y, c.y);
        // floor of the low side, ceiling of the high side
        r.min_x = scr_x_t'(clamp_px(lo_x >>> 16, `SCREEN_W - 1));
        r.max_x = scr_x_t'(clamp_px((hi_x + 65535) >>> 16, `SCREEN_W - 1));
        r.min_y = scr_y_t'(clamp_px(lo_y >>> 16, `SCREEN_H - 1));
        r.max_y = scr_y_t'(clamp_px((hi_y + 65535) >>> 16, `SCREEN_H - 1));
        r.colors[0] = a.color;
        r.colors[1] = b.color;
        r.colors[2] = c.color;
        r.depths[0] = a.z;
        r.depths[1] = b.z;
        r.depths[2] = c.z;
        return r;
    endfunction

    function automatic sub_t to_subpixel(input q16_16_t c);
        return sub_t'(longint'(c) >>> (16 - `SUB_BITS));
    endfunction

    function automatic edge_rec_t model_edge(input vertex_t a, input vertex_t b, input vertex_t c);
        edge_rec_t r;
        r.v0x  = to_subpixel(a.x);
        r.v0y  = to_subpixel(a.y);
        r.e0x  = sub_t'(to_subpixel(b.x) - r.v0x);
        r.e0y  = sub_t'(to_subpixel(b.y) - r.v0y);
        r.e1x  = sub_t'(to_subpixel(c.x) - r.v0x);
        r.e1y  = sub_t'(to_subpixel(c.y) - r.v0y);
        r.area = area_t'(longint'(r.e0x) * longint'(r.e1y) - longint'(r.e0y) * longint'(r.e1x));
        return r;
    endfunction

    task automatic model_recip(input area_t a, output inv_t q, output bit ovf);
        longint mag;
        longint quo;
        longint lim;
        mag = (a < 0) ? -longint'(a) : longint'(a);
        quo = (longint'(1) << (`INV_FBITS + 2 * `SUB_BITS)) / mag;
        // negative side reaches one step further
        lim = (longint'(1) << (`INV_BITS - 1)) - ((a < 0) ? 0 : 1);
        ovf = (quo > lim);
        if (ovf) begin
            quo = lim;
        end
        q = inv_t'((a < 0) ? -quo : quo);
    endtask

    task automatic push_expected(input vertex_t a, input vertex_t b, input vertex_t c);
        edge_rec_t e;
        inv_t      q;
        bit        ovf;
        e = model_edge(a, b, c);
        if (e.area != 0 && (!CULL_BACK || e.area < 0)) begin
            model_recip(e.area, q, ovf);
            exp_box_q.push_back(model_bbox(a, b, c));
            exp_edge_q.push_back(e);
            exp_inv_q.push_back(q);
            exp_ovf_q.push_back(ovf);
            kept_cnt++;
        end
    endtask

    task automatic check_bbox(input bbox_rec_t exp, input bbox_rec_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: box %0d %0d %0d %0d %h %h exp %0d %0d %0d %0d %h %h",
                $time, got.min_x, got.max_x, got.min_y, got.max_y, got.colors, got.depths,
                exp.min_x, exp.max_x, exp.min_y, exp.max_y, exp.colors, exp.depths);
        end
    endtask

    task automatic check_edge(input edge_rec_t exp, input edge_rec_t got);
        checks++;
        if (got.v0x !== exp.v0x || got.v0y !== exp.v0y || got.e0x !== exp.e0x
                || got.e0y !== exp.e0y || got.e1x !== exp.e1x || got.e1y !== exp.e1y) begin
            errors++;
            $display("mismatch at %0t: edges %0d %0d %0d %0d %0d %0d exp %0d %0d %0d %0d %0d %0d",
                $time, got.v0x, got.v0y, got.e0x, got.e0y, got.e1x, got.e1y,
                exp.v0x, exp.v0y, exp.e0x, exp.e0y, exp.e1x, exp.e1y);
        end
    endtask

    task automatic check_inv(input inv_t exp_q, input bit exp_ovf,
                             input inv_t got_q, input logic got_ovf);
        checks++;
        if (got_q !== exp_q || got_ovf !== exp_ovf) begin
            errors++;
            $display("mismatch at %0t: reciprocal %0d ovf %b, expected %0d ovf %b",
                $time, got_q, got_ovf, exp_q, exp_ovf);
        end
    endtask

    // compares every accepted output with the oldest kept triangle
    always @(posedge clk) begin
        if (!rst && out_valid && out_ready) begin
            out_cnt++;
            if (exp_box_q.size() == 0) begin
                errors++;
                $display("error at %0t: an output arrived with no kept triangle pending", $time);
            end else begin
                got_box.min_x  = out_min_x;
                got_box.max_x  = out_max_x;
                got_box.min_y  = out_min_y;
                got_box.max_y  = out_max_y;
                got_box.colors = out_colors;
                got_box.depths = out_depths;
                got_edge.v0x   = out_v0x;
                got_edge.v0y   = out_v0y;
                got_edge.e0x   = out_e0x;
                got_edge.e0y   = out_e0y;
                got_edge.e1x   = out_e1x;
                got_edge.e1y   = out_e1y;
                got_edge.area  = '0;
                check_bbox(exp_box_q.pop_front(), got_box);
                check_edge(exp_edge_q.pop_front(), got_edge);
                check_inv(exp_inv_q.pop_front(), exp_ovf_q.pop_front(), out_inv, out_inv_ovf);
            end
        end
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_ready = ready_random ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Test failures found");
        $finish;
    end

    function automatic vertex_t make_vertex(input real x, input real y, input real z,
                                            input color12_t col);
        vertex_t v;
        v.x     = q16_16_t'($rtoi(x * 65536.0));
        v.y     = q16_16_t'($rtoi(y * 65536.0));
        v.z     = q16_16_t'($rtoi(z * 65536.0));
        v.color = col;
        return v;
    endfunction

    function automatic vertex_t random_vertex();
        vertex_t v;
        // a margin of 32 pixels around the screen
        v.x     = q16_16_t'(int'($urandom_range(0, 384 * 65536)) - 32 * 65536);
        v.y     = q16_16_t'(int'($urandom_range(0, 304 * 65536)) - 32 * 65536);
        v.z     = q16_16_t'($urandom);
        v.color = color12_t'($urandom_range(0, 4095));
        return v;
    endfunction

    // called 1 ns after an edge, returns 1 ns after the taking edge
    task automatic send_tri(input vertex_t a, input vertex_t b, input vertex_t c);
        v0       = a;
        v1       = b;
        v2       = c;
        in_valid = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        push_expected(a, b, c);
    endtask

    task automatic wait_drain();
        // the edge pipeline needs 3 cycles to reach its queue
        repeat (4) @(posedge clk);
        #1;
        while (exp_box_q.size() != 0 || busy || out_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
        kept_mark = kept_cnt;
        out_mark  = out_cnt;
    endtask

    task automatic end_test();
        wait_drain();
        if (out_cnt - out_mark != kept_cnt - kept_mark) begin
            errors++;
            $display("error at %0t: %s gave %0d outputs for %0d kept triangles",
                $time, test_name, out_cnt - out_mark, kept_cnt - kept_mark);
        end
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - err_mark);
        end else begin
            $display("test %s: PASS", test_name);
        end
    endtask

    initial begin
        void'($urandom(32'hc9de72e7));
        rst          = 1'b1;
        in_valid     = 1'b0;
        v0           = '0;
        v1           = '0;
        v2           = '0;
        ready_random = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset and single triangle");
        if (out_valid !== 1'b0 || busy !== 1'b0 || in_ready !== 1'b1) begin
            errors++;
            $display("mismatch at %0t: after reset out_valid %b busy %b in_ready %b, expected 001",
                $time, out_valid, busy, in_ready);
        end
        send_tri(make_vertex(20.0, 10.0, 1.0, 12'hf00), make_vertex(30.5, 60.25, 2.0, 12'h0f0),
                 make_vertex(80.0, 30.0, 3.0, 12'h00f));
        end_test();

        begin_test("culled then kept");
        send_tri(make_vertex(20.0, 10.0, 1.0, 12'h123), make_vertex(80.0, 30.0, 2.0, 12'h456),
                 make_vertex(30.5, 60.25, 3.0, 12'h789));
        send_tri(make_vertex(10.0, 10.0, 1.0, 12'h111), make_vertex(20.0, 20.0, 1.0, 12'h222),
                 make_vertex(30.0, 30.0, 1.0, 12'h333));
        send_tri(make_vertex(100.0, 100.0, 4.0, 12'habc), make_vertex(100.0, 150.0, 5.0, 12'hdef),
                 make_vertex(150.0, 120.0, 6.0, 12'h0a5));
        end_test();

        begin_test("clamped and fractional bounds");
        send_tri(make_vertex(-10.5, -3.25, 1.5, 12'h800), make_vertex(50.0, 300.0, 2.5, 12'h080),
                 make_vertex(400.0, 100.0, 3.5, 12'h008));
        send_tri(make_vertex(10.25, 20.75, -1.0, 12'hfff), make_vertex(15.0, 30.5, -2.0, 12'h777),
                 make_vertex(30.75, 22.0, -3.0, 12'h000));
        end_test();

        begin_test("reciprocal range");
        // one subpixel squared of area
        send_tri(make_vertex(0.0, 0.0, 0.0, 12'h010), make_vertex(0.0, 0.0625, 0.0, 12'h020),
                 make_vertex(0.0625, 0.0, 0.0, 12'h030));
        send_tri(make_vertex(0.0, 0.0, 0.0, 12'h040), make_vertex(0.0, 100.0, 0.0, 12'h050),
                 make_vertex(100.0, 0.0, 0.0, 12'h060));
        end_test();

        begin_test("random stream");
        ready_random = 1'b1;
        repeat (200) begin
            send_tri(random_vertex(), random_vertex(), random_vertex());
        end
        end_test();
        ready_random = 1'b0;

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/triangle_setup_top.sv */
`timescale 1ns/1ps
`default_nettype none

module triangle_setup_top import vertex_pkg::*, setup_pkg::*; #(
    parameter bit cull_back = 1'b1
) (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire vertex_t   v0,
    input  wire vertex_t   v1,
    input  wire vertex_t   v2,
    input  wire logic      in_valid,
    output logic           in_ready,
    output sub_t           out_v0x,
    output sub_t           out_v0y,
    output sub_t           out_e0x,
    output sub_t           out_e0y,
    output sub_t           out_e1x,
    output sub_t           out_e1y,
    output inv_t           out_inv,
    output logic           out_inv_ovf,
    output scr_x_t         out_min_x,
    output scr_x_t         out_max_x,
    output scr_y_t         out_min_y,
    output scr_y_t         out_max_y,
    output color12_t [2:0] out_colors,
    output q16_16_t  [2:0] out_depths,
    output logic           out_valid,
    input  wire logic      out_ready,
    output logic           busy
);

    logic      box_space;
    logic      edge_space;
    logic      take;
    bbox_rec_t box_head;
    logic      box_hv;
    edge_rec_t edge_head;
    logic      edge_hv;
    logic      pop;
    logic      merge_busy;

    // both units see the same triangle on the same edge
    assign in_ready = box_space && edge_space;
    assign take     = in_valid && in_ready;
    assign busy     = merge_busy || box_hv || edge_hv;

    bbox_unit i_bbox (
        .clk        (clk),
        .rst        (rst),
        .take       (take),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .space_ok   (box_space),
        .head       (box_head),
        .head_valid (box_hv),
        .pop        (pop)
    );

    edge_unit i_edge (
        .clk        (clk),
        .rst        (rst),
        .take       (take),
        .v0         (v0),
        .v1         (v1),
        .v2         (v2),
        .space_ok   (edge_space),
        .head       (edge_head),
        .head_valid (edge_hv),
        .pop        (pop)
    );

    setup_merge #(
        .cull_back (cull_back)
    ) i_merge (
        .clk         (clk),
        .rst         (rst),
        .box         (box_head),
        .box_valid   (box_hv),
        .edges       (edge_head),
        .edge_valid  (edge_hv),
        .pop         (pop),
        .out_v0x     (out_v0x),
        .out_v0y     (out_v0y),
        .out_e0x     (out_e0x),
        .out_e0y     (out_e0y),
        .out_e1x     (out_e1x),
        .out_e1y     (out_e1y),
        .out_inv     (out_inv),
        .out_inv_ovf (out_inv_ovf),
        .out_min_x   (out_min_x),
        .out_max_x   (out_max_x),
        .out_min_y   (out_min_y),
        .out_max_y   (out_max_y),
        .out_colors  (out_colors),
        .out_depths  (out_depths),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .busy        (merge_busy)
    );

endmodule

`default_nettype wire

/* rtl/setup_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module setup_merge import vertex_pkg::*, setup_pkg::*; #(
    parameter bit cull_back = 1'b1
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire bbox_rec_t  box,
    input  wire logic       box_valid,
    input  wire edge_rec_t  edges,
    input  wire logic       edge_valid,
    output logic            pop,
    output sub_t            out_v0x,
    output sub_t            out_v0y,
    output sub_t            out_e0x,
    output sub_t            out_e0y,
    output sub_t            out_e1x,
    output sub_t            out_e1y,
    output inv_t            out_inv,
    output logic            out_inv_ovf,
    output scr_x_t          out_min_x,
    output scr_x_t          out_max_x,
    output scr_y_t          out_min_y,
    output scr_y_t          out_max_y,
    output color12_t [2:0]  out_colors,
    output q16_16_t  [2:0]  out_depths,
    output logic            out_valid,
    input  wire logic       out_ready,
    output logic            busy
);

    typedef enum logic [1:0] {M_IDLE, M_WAIT, M_PRESENT} mstate_t;

    mstate_t   state;
    bbox_rec_t box_q;
    edge_rec_t edge_q;
    logic      keep;
    logic      start_q;
    logic      r_busy;
    logic      r_done;
    inv_t      r_quot;
    logic      r_ovf;

    assign pop  = (state == M_IDLE) && box_valid && edge_valid;
    // zero area is degenerate, non-negative area faces away
    assign keep = (edges.area != '0) && (!cull_back || edges.area[$bits(area_t)-1]);
    assign busy = (state != M_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= M_IDLE;
            start_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (pop && keep) begin
                        start_q <= 1'b1;
                        state   <= M_WAIT;
                    end
                end
                M_WAIT: begin
                    if (r_done) begin
                        out_valid <= 1'b1;
                        state     <= M_PRESENT;
                    end
                end
                default: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        state     <= M_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop && keep) begin
            box_q  <= box;
            edge_q <= edges;
        end
        if (state == M_WAIT && r_done) begin
            out_inv     <= r_quot;
            out_inv_ovf <= r_ovf;
        end
    end

    recip_unit i_recip (
        .clk      (clk),
        .rst      (rst),
        .start    (start_q),
        .area     (edge_q.area),
        .busy     (r_busy),
        .done     (r_done),
        .quotient (r_quot),
        .ovf      (r_ovf)
    );

    // held pair stays put until the next pop
    assign out_v0x    = edge_q.v0x;
    assign out_v0y    = edge_q.v0y;
    assign out_e0x    = edge_q.e0x;
    assign out_e0y    = edge_q.e0y;
    assign out_e1x    = edge_q.e1x;
    assign out_e1y    = edge_q.e1y;
    assign out_min_x  = box_q.min_x;
    assign out_max_x  = box_q.max_x;
    assign out_min_y  = box_q.min_y;
    assign out_max_y  = box_q.max_y;
    assign out_colors = box_q.colors;
    assign out_depths = box_q.depths;

    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_inv) && $stable(out_inv_ovf)
            && $stable(box_q) && $stable(edge_q));

    a_recip_active: assert property (@(posedge clk) disable iff (rst)
        state == M_WAIT && !start_q |-> r_busy || r_done);

endmodule

`default_nettype wire

/* rtl/recip_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "setup_macros.svh"

module recip_unit import setup_pkg::*; (
    input  wire logic  clk,
    input  wire logic  rst,
    input  wire logic  start,
    input  wire area_t area,
    output logic       busy,
    output logic       done,
    output inv_t       quotient,
    output logic       ovf
);

    localparam int MAG_W = $bits(area_t);
    localparam int REM_W = MAG_W + 1;
    localparam int CNT_W = $clog2(`INV_BITS);
    // dividend bits above the quotient window, preloaded into the remainder
    localparam int PRE_SHIFT = `INV_FBITS + 2 * `SUB_BITS - `INV_BITS;
    localparam logic [REM_W-1:0] REM_INIT = REM_W'(1) << PRE_SHIFT;
    localparam logic [`INV_BITS-1:0] POS_LIM = {1'b0, {(`INV_BITS - 1){1'b1}}};

    typedef enum logic [1:0] {R_IDLE, R_RUN, R_FIN} rstate_t;

    rstate_t              state;
    logic [CNT_W-1:0]     cnt;
    logic [MAG_W-1:0]     mag;
    logic [MAG_W-1:0]     divisor;
    logic [REM_W-1:0]     rem;
    logic [REM_W-1:0]     rem_sh;
    logic [`INV_BITS-1:0] q;
    logic                 ge;
    logic                 neg;
    logic                 pre_ovf;
    logic                 fits;

    assign mag    = area[MAG_W-1] ? -area : area;
    assign rem_sh = {rem[REM_W-2:0], 1'b0};
    assign ge     = rem_sh >= {1'b0, divisor};
    // one more step of magnitude on the negative side
    assign fits   = !pre_ovf && ((q <= POS_LIM) || (neg && q == POS_LIM + 1'b1));
    assign busy   = (state != R_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= R_IDLE;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                R_IDLE: begin
                    if (start) begin
                        state <= R_RUN;
                        cnt   <= CNT_W'(`INV_BITS - 1);
                    end
                end
                R_RUN: begin
                    if (cnt == '0) begin
                        state <= R_FIN;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= R_IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == R_IDLE && start) begin
            divisor <= mag;
            neg     <= area[MAG_W-1];
            pre_ovf <= (mag <= MAG_W'(REM_INIT));
            rem     <= REM_INIT;
            q       <= '0;
        end else if (state == R_RUN) begin
            rem <= ge ? rem_sh - {1'b0, divisor} : rem_sh;
            q   <= {q[`INV_BITS-2:0], ge};
        end else if (state == R_FIN) begin
            if (fits) begin
                quotient <= neg ? inv_t'(-q) : inv_t'(q);
            end else begin
                quotient <= neg ? inv_t'(~POS_LIM) : inv_t'(POS_LIM);
            end
            ovf <= !fits;
        end
    end

    a_start_legal: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy && area != '0);

endmodule

`default_nettype wire

/* rtl/edge_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "setup_macros.svh"

module edge_unit import vertex_pkg::*, setup_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    take,
    input  wire vertex_t v0,
    input  wire vertex_t v1,
    input  wire vertex_t v2,
    output logic         space_ok,
    output edge_rec_t    head,
    output logic         head_valid,
    input  wire logic    pop
);

    edge_rec_t s1_next;
    edge_rec_t s1_rec;
    edge_rec_t s2_rec;
    area_t     area_d;
    logic      s1_valid;
    logic      s2_valid;
    logic [$clog2(`QUEUE_DEPTH+1)-1:0] q_count;

    // drop the low fraction bits below the subpixel grid
    function automatic sub_t snap(input q16_16_t c);
        return c[31:16-`SUB_BITS];
    endfunction

    always_comb begin
        s1_next.v0x  = snap(v0.x);
        s1_next.v0y  = snap(v0.y);
        s1_next.e0x  = snap(v1.x) - s1_next.v0x;
        s1_next.e0y  = snap(v1.y) - s1_next.v0y;
        s1_next.e1x  = snap(v2.x) - s1_next.v0x;
        s1_next.e1y  = snap(v2.y) - s1_next.v0y;
        s1_next.area = '0;
    end

    // doubled signed area, negative for counter-clockwise
    assign area_d = area_t'(s1_rec.e0x) * area_t'(s1_rec.e1y)
                  - area_t'(s1_rec.e0y) * area_t'(s1_rec.e1x);

    always_ff @(posedge clk) begin
        s1_rec      <= s1_next;
        s2_rec      <= s1_rec;
        s2_rec.area <= area_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= take;
            s2_valid <= s1_valid;
        end
    end

    // both stages may still land in the queue
    assign space_ok = (int'(q_count) + int'(s1_valid) + int'(s2_valid)) < `QUEUE_DEPTH;

    payload_fifo #(
        .payload_t (edge_rec_t),
        .DEPTH     (`QUEUE_DEPTH)
    ) i_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (s2_valid),
        .din       (s2_rec),
        .pop       (pop),
        .dout      (head),
        .not_empty (head_valid),
        .full      (),
        .count     (q_count)
    );

endmodule

`default_nettype wire

/* rtl/bbox_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "setup_macros.svh"

module bbox_unit import vertex_pkg::*, setup_pkg::*; (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    take,
    input  wire vertex_t v0,
    input  wire vertex_t v1,
    input  wire vertex_t v2,
    output logic         space_ok,
    output bbox_rec_t    head,
    output logic         head_valid,
    input  wire logic    pop
);

    bbox_rec_t rec_d;
    bbox_rec_t rec_q;
    logic      rec_valid;
    logic [$clog2(`QUEUE_DEPTH+1)-1:0] q_count;

    // floor of the smallest or ceiling of the largest, clamped to [0, hi]
    function automatic int axis_bound(input q16_16_t a, input q16_16_t b, input q16_16_t c,
                                      input bit upper, input int hi);
        logic signed [32:0] v;
        if (upper) begin
            v = (a > b) ? a : b;
            v = (v > c) ? v : c;
            v = (v + 33'sh0ffff) >>> 16;
        end else begin
            v = (a < b) ? a : b;
            v = (v < c) ? v : c;
            v = v >>> 16;
        end
        if (v < 0) begin
            return 0;
        end
        if (v > hi) begin
            return hi;
        end
        return int'(v[31:0]);
    endfunction

    always_comb begin
        rec_d.min_x  = scr_x_t'(axis_bound(v0.x, v1.x, v2.x, 1'b0, `SCREEN_W - 1));
        rec_d.max_x  = scr_x_t'(axis_bound(v0.x, v1.x, v2.x, 1'b1, `SCREEN_W - 1));
        rec_d.min_y  = scr_y_t'(axis_bound(v0.y, v1.y, v2.y, 1'b0, `SCREEN_H - 1));
        rec_d.max_y  = scr_y_t'(axis_bound(v0.y, v1.y, v2.y, 1'b1, `SCREEN_H - 1));
        rec_d.colors = {v2.color, v1.color, v0.color};
        rec_d.depths = {v2.z, v1.z, v0.z};
    end

    always_ff @(posedge clk) begin
        rec_q <= rec_d;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= take;
        end
    end

    // room for the staged record plus one more
    assign space_ok = (int'(q_count) + int'(rec_valid)) < `QUEUE_DEPTH;

    payload_fifo #(
        .payload_t (bbox_rec_t),
        .DEPTH     (`QUEUE_DEPTH)
    ) i_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (rec_valid),
        .din       (rec_q),
        .pop       (pop),
        .dout      (head),
        .not_empty (head_valid),
        .full      (),
        .count     (q_count)
    );

endmodule

`default_nettype wire

/* rtl/payload_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module payload_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic                       clk,
    input  wire logic                       rst,
    input  wire logic                       push,
    input  wire payload_t                   din,
    input  wire logic                       pop,
    output payload_t                        dout,
    output logic                            not_empty,
    output logic                            full,
    output logic [$clog2(DEPTH+1)-1:0]      count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign dout      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop |-> not_empty);

endmodule

`default_nettype wire

/* rtl/setup_pkg.sv */
`default_nettype none

`include "setup_macros.svh"

package setup_pkg;

    import vertex_pkg::*;

    // 16 integer bits plus subpixel fraction
    typedef logic signed [16+`SUB_BITS-1:0] sub_t;
    typedef logic signed [2*(16+`SUB_BITS)-1:0] area_t;
    typedef logic signed [`INV_BITS-1:0] inv_t;

    typedef logic [$clog2(`SCREEN_W)-1:0] scr_x_t;
    typedef logic [$clog2(`SCREEN_H)-1:0] scr_y_t;

    typedef struct packed {
        scr_x_t         min_x;
        scr_x_t         max_x;
        scr_y_t         min_y;
        scr_y_t         max_y;
        color12_t [2:0] colors;
        q16_16_t  [2:0] depths;
    } bbox_rec_t;

    typedef struct packed {
        sub_t  v0x;
        sub_t  v0y;
        sub_t  e0x;
        sub_t  e0y;
        sub_t  e1x;
        sub_t  e1y;
        area_t area;
    } edge_rec_t;

endpackage

`default_nettype wire

/* rtl/vertex_pkg.sv */
`default_nettype none

package vertex_pkg;

    // signed Q16.16
    typedef logic signed [31:0] q16_16_t;

    // rgb444, red in the top nibble
    typedef logic [11:0] color12_t;

    typedef struct packed {
        q16_16_t  x;
        q16_16_t  y;
        q16_16_t  z;
        color12_t color;
    } vertex_t;

endpackage

`default_nettype wire

/* rtl/setup_macros.svh */
`ifndef SETUP_MACROS_SVH
`define SETUP_MACROS_SVH

// screen size in pixels
`define SCREEN_W 320
`define SCREEN_H 240

// fraction bits kept after snapping
`define SUB_BITS 4

// reciprocal of the doubled area
`define INV_BITS  36
`define INV_FBITS 35

// entries per side queue
`define QUEUE_DEPTH 4

`endif
